/* include/pong_macros.svh */
`ifndef PONG_MACROS_SVH
`define PONG_MACROS_SVH

// screen sizes in pixels
`define PONG_W_FULL      640
`define PONG_H_FULL      480
`define PONG_W_SMALL     320
`define PONG_H_SMALL     240

`define PONG_BALL_SIZE   20
`define PONG_X_STEP      4       // horizontal pixels moved per step

// where the ball sits after reset
`define PONG_START_X     100
`define PONG_START_Y     80
`define PONG_START_VY    (-3)

`define PONG_BASE_PERIOD 270000  // clock cycles per step with no swing applied

`define PONG_PADDLE_H    60
`define PONG_PADDLE_ZONE 24      // band left of the right edge where the paddle can reach

`endif

/* logic/ball_physics.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_macros.svh"

module ball_physics
    import pong_pkg::*;
(
    input  logic       clk_25MHZ,
    input  logic       reset,
    input  logic       step,
    input  logic       serve,
    input  logic       upscale,
    output coord_t     ball_y,
    output vel_t       ball_vy,
    output logic [1:0] gravity_phase
);

    coord_t             floor_y;
    vel_t               vy_next;
    logic signed [11:0] y_sum;   // wide enough to see both walls overshot

    assign floor_y = upscale ? coord_t'(`PONG_H_FULL - 1) : coord_t'(`PONG_H_SMALL - 1);

    // gravity adds one pixel per step of speed every fourth step
    assign vy_next = (gravity_phase == 2'd3) ? ball_vy + vel_t'(1) : ball_vy;

    // position moves with the velocity from before this step
    assign y_sum = $signed({2'b00, ball_y}) + $signed({{2{ball_vy[9]}}, ball_vy});

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vertical state, updated once per step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            ball_y        <= coord_t'(`PONG_START_Y);
            ball_vy       <= vel_t'(`PONG_START_VY);
            gravity_phase <= 2'd0;
        end else if (serve) begin
            gravity_phase <= 2'd0;  // y and vy carry over so the other board sees a smooth path
        end else if (step) begin
            gravity_phase <= gravity_phase + 2'd1;
            if (y_sum >= $signed({2'b00, floor_y})) begin
                ball_y  <= floor_y;
                ball_vy <= -vy_next;
            end else if (y_sum <= 12'sd0) begin
                ball_y  <= '0;
                ball_vy <= -vy_next;
            end else begin
                ball_y  <= coord_t'(y_sum);
                ball_vy <= vy_next;
            end
        end
    end

    // a step always leaves the ball on the screen that was selected when it was taken
    a_y_on_screen : assert property (@(posedge clk_25MHZ) disable iff (reset)
        step && !serve |=> (ball_y <= $past(floor_y)));

endmodule

`default_nettype wire

/* logic/paddle_collision.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_macros.svh"

module paddle_collision
    import pong_pkg::*;
(
    input  logic   clk_25MHZ,
    input  logic   reset,
    input  coord_t ball_x,
    input  coord_t ball_y,
    input  coord_t paddle_y,
    input  logic   moving_right,
    input  logic   upscale,
    output logic   hit
);

    coord_t edge_x;
    logic   in_zone;
    logic   span_overlap;
    logic   overlap;
    logic   overlap_q;  // overlap one cycle ago, for the rising edge

    assign edge_x = upscale ? coord_t'(`PONG_W_FULL) : coord_t'(`PONG_W_SMALL);

    // right side of the ball has entered the paddle band
    assign in_zone = ({1'b0, ball_x} + 11'(`PONG_BALL_SIZE))
                     >= ({1'b0, edge_x} - 11'(`PONG_PADDLE_ZONE));

    assign span_overlap = ({1'b0, ball_y} < {1'b0, paddle_y} + 11'(`PONG_PADDLE_H))
                          && ({1'b0, paddle_y} < {1'b0, ball_y} + 11'(`PONG_BALL_SIZE));

    assign overlap = moving_right && in_zone && span_overlap;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            overlap_q <= 1'b0;
            hit       <= 1'b0;
        end else begin
            overlap_q <= overlap;
            hit       <= overlap && !overlap_q;  // one pulse per entry into the zone
        end
    end

endmodule

`default_nettype wire

/* logic/pong_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_macros.svh"

module pong_core
    import pong_pkg::*;
#(
    parameter int unsigned base_period = `PONG_BASE_PERIOD
) (
    input  logic       clk_25MHZ,
    input  logic       reset,
    input  logic       upscale,
    input  logic       game_start,
    input  coord_t     paddle_y,
    input  speed_t     estimated_speed,
    output coord_t     ball_x,
    output coord_t     ball_y,
    output logic       moving_left,
    output logic       game_over,
    output score_t     score,
    output logic       ball_send,
    output vel_t       ball_vy,
    output logic [1:0] gravity_phase
);

    logic step;
    logic hit;
    logic run;
    logic serve;
    logic moving_right;

    assign moving_right = run && !moving_left;  // only a ball heading for the paddle can hit

    step_timer #(
        .base_period(base_period)
    ) u_step_timer (
        .clk_25MHZ      (clk_25MHZ),
        .reset          (reset),
        .run            (run),
        .serve          (serve),
        .hit            (hit),
        .estimated_speed(estimated_speed),
        .step           (step)
    );

    ball_physics u_ball_physics (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .step         (step),
        .serve        (serve),
        .upscale      (upscale),
        .ball_y       (ball_y),
        .ball_vy      (ball_vy),
        .gravity_phase(gravity_phase)
    );

    paddle_collision u_paddle_collision (
        .clk_25MHZ   (clk_25MHZ),
        .reset       (reset),
        .ball_x      (ball_x),
        .ball_y      (ball_y),
        .paddle_y    (paddle_y),
        .moving_right(moving_right),
        .upscale     (upscale),
        .hit         (hit)
    );

    rally_fsm u_rally_fsm (
        .clk_25MHZ  (clk_25MHZ),
        .reset      (reset),
        .game_start (game_start),
        .step       (step),
        .hit        (hit),
        .upscale    (upscale),
        .ball_x     (ball_x),
        .moving_left(moving_left),
        .run        (run),
        .serve      (serve),
        .score      (score),
        .game_over  (game_over),
        .ball_send  (ball_send)
    );

endmodule

`default_nettype wire

/* logic/pong_pkg.sv */
`default_nettype none

package pong_pkg;

    // rally states, same encoding as the game controller on the other board
    typedef enum logic [1:0] {
        RALLY_IDLE  = 2'd0,
        RALLY_RIGHT = 2'd1,
        RALLY_LEFT  = 2'd2,
        RALLY_STOP  = 2'd3
    } rally_state_t;

    typedef logic [9:0]        coord_t;  // pixel coordinate, top left is 0,0
    typedef logic signed [9:0] vel_t;    // vertical pixels per step, down is positive
    typedef logic [9:0]        speed_t;  // swing speed estimated on the sensor side
    typedef logic [7:0]        score_t;

endpackage

`default_nettype wire

/* logic/rally_fsm.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_macros.svh"

module rally_fsm
    import pong_pkg::*;
(
    input  logic   clk_25MHZ,
    input  logic   reset,
    input  logic   game_start,
    input  logic   step,
    input  logic   hit,
    input  logic   upscale,
    output coord_t ball_x,
    output logic   moving_left,
    output logic   run,
    output logic   serve,
    output score_t score,
    output logic   game_over,
    output logic   ball_send
);

    rally_state_t state;
    coord_t       edge_x;  // x at which the ball has passed the paddle

    assign edge_x = upscale ? coord_t'(`PONG_W_FULL - `PONG_BALL_SIZE)
                            : coord_t'(`PONG_W_SMALL - `PONG_BALL_SIZE);

    assign run         = (state == RALLY_RIGHT) || (state == RALLY_LEFT);
    assign moving_left = (state == RALLY_LEFT);

    // new game from idle or stop, or the ball coming back after leaving on the left
    assign serve = ((state == RALLY_IDLE || state == RALLY_STOP) && game_start)
                   || (state == RALLY_LEFT && ball_x == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rally state, horizontal position and score
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state     <= RALLY_IDLE;
            ball_x    <= coord_t'(`PONG_START_X);
            score     <= '0;
            game_over <= 1'b0;
            ball_send <= 1'b0;
        end else begin
            case (state)
                RALLY_IDLE: begin
                    if (game_start) begin
                        state <= RALLY_LEFT;
                    end
                end

                RALLY_LEFT: begin
                    if (ball_x == '0) begin
                        state <= RALLY_RIGHT;  // ball went over to the other board
                        score <= score + score_t'(1);
                    end else if (step) begin
                        ball_x <= (ball_x < coord_t'(`PONG_X_STEP)) ? '0
                                  : ball_x - coord_t'(`PONG_X_STEP);
                    end
                end

                RALLY_RIGHT: begin
                    if (hit) begin
                        state <= RALLY_LEFT;
                    end else if (ball_x >= edge_x) begin
                        state     <= RALLY_STOP;  // missed the paddle
                        game_over <= 1'b1;
                        ball_send <= 1'b1;
                    end else if (step) begin
                        ball_x <= ball_x + coord_t'(`PONG_X_STEP);
                    end
                end

                RALLY_STOP: begin
                    if (game_start) begin
                        state     <= RALLY_LEFT;
                        score     <= '0;
                        game_over <= 1'b0;
                        ball_send <= 1'b0;
                    end
                end

                default: state <= RALLY_IDLE;
            endcase
        end
    end

    a_send_in_game_over : assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball_send |-> game_over);

endmodule

`default_nettype wire

/* logic/step_timer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_macros.svh"

module step_timer
    import pong_pkg::*;
#(
    parameter int unsigned base_period = `PONG_BASE_PERIOD
) (
    input  logic   clk_25MHZ,
    input  logic   reset,
    input  logic   run,
    input  logic   serve,
    input  logic   hit,
    input  speed_t estimated_speed,
    output logic   step
);

    localparam int unsigned PERIOD_W = $clog2(base_period + 1);

    logic [PERIOD_W-1:0] period;
    logic [PERIOD_W-1:0] count;
    logic [PERIOD_W-1:0] hit_period;
    speed_t              safe_speed;
    logic [31:0]         quotient;

    // a slow swing counts as 1 so a hit never slows the ball down
    assign safe_speed = (estimated_speed < speed_t'(2)) ? speed_t'(1) : estimated_speed;
    assign quotient   = base_period / {22'd0, safe_speed};
    assign hit_period = (quotient == 32'd0) ? PERIOD_W'(1) : PERIOD_W'(quotient);

    assign step = run && (count >= period);  // >= so a shorter period loaded mid-count still ends

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            period <= PERIOD_W'(base_period);
            count  <= '0;
        end else if (serve) begin
            period <= PERIOD_W'(base_period);  // every new rally starts at base speed
            count  <= '0;
        end else begin
            if (hit) begin
                period <= hit_period;
            end
            if (step) begin
                count <= '0;
            end else if (run) begin
                count <= count + 1'b1;
            end
        end
    end

    a_period_nonzero : assert property (@(posedge clk_25MHZ) disable iff (reset)
        hit |=> (period != '0));

endmodule

`default_nettype wire

/* project.f */
+incdir+include
logic/pong_pkg.sv
logic/step_timer.sv
logic/ball_physics.sv
logic/paddle_collision.sv
logic/rally_fsm.sv
logic/pong_core.sv
test/clock_gen.sv
test/pong_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the pong testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module pong_tb \
    -f project.f \
    -o pong_sim

./obj_dir/pong_sim

/* test/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clk_25MHZ,
    output logic reset
);

    initial begin
        clk_25MHZ = 1'b0;
        forever #20 clk_25MHZ = ~clk_25MHZ;  // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk_25MHZ);
        #2 reset = 1'b0;
    end

endmodule

`default_nettype wire

/* test/pong_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_macros.svh"

module pong_tb
    import pong_pkg::*;
();

    localparam int BASE  = 8;
    localparam int NUM   = 6;
    // every leg is at most 155 steps of BASE+1 cycles, plus the game over waits
    localparam int LIMIT = (25 + NUM * 2 * 155) * (BASE + 1) + NUM * 64 + 500;

    logic       clk_25MHZ;
    logic       reset;
    logic       upscale;
    logic       game_start;
    coord_t     paddle_y;
    speed_t     estimated_speed;
    coord_t     ball_x;
    coord_t     ball_y;
    logic       moving_left;
    logic       game_over;
    score_t     score;
    logic       ball_send;
    vel_t       ball_vy;
    logic [1:0] gravity_phase;

    // one rally per entry: full screen, paddle on the ball, swing speed, expected hit
    int tab_up  [NUM] = '{0, 0, 1, 1, 0, 1};
    int tab_on  [NUM] = '{1, 0, 1, 0, 1, 1};
    int tab_spd [NUM] = '{4, 2, 3, 5, 20, 2};
    int tab_hit [NUM] = '{1, 0, 1, 0, 1, 1};

    int          m_x;
    int          m_y;
    int          m_vy;
    int          m_phase;
    int          m_score;
    int          m_period;
    int          m_left;
    int          last_step;
    int          first_step;
    int          cycles = 0;

    clock_gen u_clock_gen (.clk_25MHZ(clk_25MHZ), .reset(reset));

    pong_core #(.base_period(BASE)) u_dut (.*);

    always @(posedge clk_25MHZ) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("tests failed");
            $fatal(1, "timeout: the ball engine ran past %0d cycles", LIMIT);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fail_value(string what, int got, int exp);
        $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        $display("tests failed");
        $fatal(1, "wrong value from the DUT");
    endtask

    task automatic check_coord(string what, coord_t got, int exp);
        if (got !== coord_t'(exp)) fail_value(what, int'(got), exp);
    endtask

    task automatic check_vel(string what, vel_t got, int exp);
        if (got !== vel_t'(exp)) fail_value(what, int'(got), exp);
    endtask

    task automatic check_score(string what, score_t got, int exp);
        if (got !== score_t'(exp)) fail_value(what, int'(got), exp);
    endtask

    task automatic check_bit(string what, logic got, int exp);
        if (got !== exp[0]) fail_value(what, int'(got), exp);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and rally legs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic next_cycle();
        @(posedge clk_25MHZ);
        #1;
    endtask

    task automatic model_step();
        int floor_y;
        int vy_next;
        int y_sum;
        floor_y = upscale ? `PONG_H_FULL - 1 : `PONG_H_SMALL - 1;
        vy_next = (m_phase == 3) ? m_vy + 1 : m_vy;  // gravity every fourth step
        y_sum   = m_y + m_vy;
        if (y_sum >= floor_y) begin
            m_y  = floor_y;
            m_vy = -vy_next;
        end else if (y_sum <= 0) begin
            m_y  = 0;
            m_vy = -vy_next;
        end else begin
            m_y  = y_sum;
            m_vy = vy_next;
        end
        m_phase = (m_phase + 1) % 4;
        m_x     = (m_left != 0) ? m_x - `PONG_X_STEP : m_x + `PONG_X_STEP;
    endtask

    task automatic follow_cycle();
        next_cycle();
        if (ball_x !== coord_t'(m_x)) begin
            model_step();
            check_coord("ball_x", ball_x, m_x);
            check_coord("ball_y", ball_y, m_y);
            check_vel("ball_vy", ball_vy, m_vy);
            check_coord("gravity_phase", coord_t'(gravity_phase), m_phase);
            if (first_step == 0) begin
                if (cycles - last_step != m_period + 1)
                    fail_value("step spacing", cycles - last_step, m_period + 1);
            end
            last_step  = cycles;
            first_step = 0;
        end
    endtask

    function automatic coord_t place_paddle(int i);
        int h;
        int w;
        h = (tab_up[i] != 0) ? `PONG_H_FULL : `PONG_H_SMALL;
        w = (tab_up[i] != 0) ? `PONG_W_FULL : `PONG_W_SMALL;
        if (m_x < w - `PONG_PADDLE_ZONE - `PONG_BALL_SIZE - 8)
            return coord_t'($urandom % h);  // far from the zone, any position will do
        if (tab_on[i] != 0)
            return coord_t'((m_y >= 20) ? m_y - 20 : 0);
        return coord_t'((m_y < h / 2) ? h - `PONG_PADDLE_H : 0);
    endfunction

    task automatic run_left();
        first_step = 1;
        while (m_x != 0) begin
            follow_cycle();
            #1 paddle_y = coord_t'($urandom % `PONG_H_SMALL);
        end
        next_cycle();  // the serve turns the ball around
        m_score  = m_score + 1;
        m_left   = 0;
        m_phase  = 0;
        m_period = BASE;
        check_score("score", score, m_score);
        check_bit("moving_left", moving_left, 0);
    endtask

    task automatic run_right(int i);
        int sp;
        int q;
        #1;
        upscale         = tab_up[i][0];
        estimated_speed = speed_t'(tab_spd[i]);
        paddle_y        = place_paddle(i);
        first_step      = 1;
        while (!moving_left && !game_over) begin
            follow_cycle();
            #1 paddle_y = place_paddle(i);
        end
        check_bit("paddle hit", moving_left, tab_hit[i]);
        if (moving_left) begin
            sp       = (tab_spd[i] < 2) ? 1 : tab_spd[i];
            q        = BASE / sp;
            m_period = (q == 0) ? 1 : q;
            m_left   = 1;
        end else begin
            check_coord("ball_x at the edge", ball_x,
                        ((tab_up[i] != 0) ? `PONG_W_FULL : `PONG_W_SMALL) - `PONG_BALL_SIZE);
            repeat (20) begin
                next_cycle();
                check_bit("game_over", game_over, 1);
                check_bit("ball_send", ball_send, 1);
                check_coord("ball_x held", ball_x, m_x);
            end
            #1 game_start = 1'b1;
            next_cycle();
            check_bit("game_over", game_over, 0);
            check_bit("ball_send", ball_send, 0);
            check_score("score", score, 0);
            check_bit("moving_left", moving_left, 1);
            #1 game_start = 1'b0;
            m_score  = 0;
            m_left   = 1;
            m_phase  = 0;
            m_period = BASE;
        end
    endtask

    initial begin
        void'($urandom(32'hb076));
        upscale         = 1'b0;
        game_start      = 1'b0;
        paddle_y        = '0;
        estimated_speed = '0;
        m_x             = `PONG_START_X;
        m_y             = `PONG_START_Y;
        m_vy            = `PONG_START_VY;
        m_phase         = 0;
        m_score         = 0;
        m_left          = 0;
        m_period        = BASE;

        @(negedge reset);
        next_cycle();
        check_coord("ball_x", ball_x, m_x);
        check_coord("ball_y", ball_y, m_y);
        check_score("score", score, 0);
        check_bit("moving_left", moving_left, 0);
        check_bit("game_over", game_over, 0);
        check_bit("ball_send", ball_send, 0);

        #1 game_start = 1'b1;
        next_cycle();
        check_bit("moving_left", moving_left, 1);
        #1 game_start = 1'b0;
        m_left = 1;
        run_left();

        for (int i = 0; i < NUM; i++) begin
            run_right(i);
            run_left();
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
